// File: hw/mem_pkg.sv
package mem_pkg;

    localparam int data_w      = 32;
    localparam int reg_addr_w  = 5;
    localparam int sram_addr_w = 10;  // Word address, 4 KiB of data memory.

    // Load operation carried with each instruction.
    // ld_none marks a non-load that writes back its ALU result.
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        lb      = 3'd1,
        lbu     = 3'd2,
        lh      = 3'd3,
        lhu     = 3'd4,
        lw      = 3'd5,
        lwl     = 3'd6,
        lwr     = 3'd7
    } ld_op_e;

    // Execute to memory stage.
    typedef struct packed {
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     alu_result;  // Load address for loads.
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        ld_op_e                ld_op;
    } es_to_ms_t;

    // Memory to write-back stage.
    typedef struct packed {
        logic [data_w-1:0]     pc;
        logic [data_w-1:0]     final_result;
        logic [reg_addr_w-1:0] dest;
        logic [3:0]            rf_wstrb;  // One enable per register byte.
    } ms_to_ws_t;

endpackage

// File: hw/stage_if.sv
`timescale 1ns/1ps

interface stage_if #(
    parameter type payload_t = logic
) ();

    logic     valid;
    logic     allowin;
    payload_t payload;

    // Upstream stage.
    modport producer (
        output valid,
        output payload,
        input  allowin
    );

    // Downstream stage.
    modport consumer (
        input  valid,
        input  payload,
        output allowin
    );

    // Observes the handshake without taking part.
    modport monitor (
        input valid,
        input allowin,
        input payload
    );

endinterface

// File: hw/data_sram.sv
`timescale 1ns/1ps

module data_sram #(
    parameter int ADDR_W = mem_pkg::sram_addr_w
) (
    input  logic                        clk,
    input  logic                        pre_en,
    input  logic [ADDR_W-1:0]           pre_addr,
    input  logic [mem_pkg::data_w-1:0]  pre_data,
    input  logic [3:0]                  pre_strb,
    stage_if.monitor                    es,
    output logic [mem_pkg::data_w-1:0]  rdata
);
    import mem_pkg::*;

    logic [data_w-1:0] mem [2**ADDR_W];
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;

    // Read only on an accepted load, so a stalled load keeps its data.
    assign rd_en   = es.valid && es.allowin && (es.payload.ld_op != ld_none);
    assign rd_addr = es.payload.alu_result[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (pre_en) begin
            for (int i = 0; i < 4; i++) begin
                if (pre_strb[i]) begin
                    mem[pre_addr][8*i +: 8] <= pre_data[8*i +: 8];
                end
            end
        end
        if (rd_en) begin
            rdata <= mem[rd_addr];
        end
    end

    // Read-during-write to one word has no defined result here.
    a_no_rw_collision: assert property (
        @(posedge clk) !(pre_en && rd_en && (pre_addr == rd_addr))
    ) else $error("preload and load hit word %0h in one cycle", rd_addr);

endmodule

// File: hw/ld_decode.sv
`timescale 1ns/1ps

module ld_decode (
    input  mem_pkg::ld_op_e ld_op,
    input  logic [1:0]      addr_lo,
    input  logic            gr_we,
    output logic [1:0]      lane_sel,
    output logic [3:0]      rf_wstrb
);
    import mem_pkg::*;

    // Byte shift. lwl shifts left, every other load shifts right.
    always_comb begin
        case (ld_op)
            lb, lbu, lh, lhu, lw, lwr: lane_sel = addr_lo;
            lwl:                       lane_sel = 2'd3 - addr_lo;
            default:                   lane_sel = 2'd0;
        endcase
    end

    // Partial word merge for unaligned loads.
    always_comb begin
        if (!gr_we) begin
            rf_wstrb = 4'b0000;
        end else if (ld_op == lwl) begin
            case (addr_lo)
                2'd0:    rf_wstrb = 4'b1000;
                2'd1:    rf_wstrb = 4'b1100;
                2'd2:    rf_wstrb = 4'b1110;
                default: rf_wstrb = 4'b1111;
            endcase
        end else if (ld_op == lwr) begin
            case (addr_lo)
                2'd0:    rf_wstrb = 4'b1111;
                2'd1:    rf_wstrb = 4'b0111;
                2'd2:    rf_wstrb = 4'b0011;
                default: rf_wstrb = 4'b0001;
            endcase
        end else begin
            rf_wstrb = 4'b1111;
        end
    end

    // The execute stage must have trapped misaligned accesses.
    always_comb begin
        if (ld_op == lh || ld_op == lhu) begin
            a_half_aligned: assert (addr_lo[0] == 1'b0)
                else $error("misaligned halfword load, offset %0d", addr_lo);
        end
        if (ld_op == lw) begin
            a_word_aligned: assert (addr_lo == 2'd0)
                else $error("misaligned word load, offset %0d", addr_lo);
        end
    end

endmodule

// File: hw/ld_select.sv
`timescale 1ns/1ps

module ld_select (
    input  mem_pkg::ld_op_e             ld_op,
    input  logic [1:0]                  lane_sel,
    input  logic [mem_pkg::data_w-1:0]  rdata,
    output logic [mem_pkg::data_w-1:0]  mem_result
);
    import mem_pkg::*;

    logic [data_w-1:0] shifted;
    logic [4:0]        bit_shift;

    assign bit_shift = {lane_sel, 3'b000};

    // lwl fills the register from the top, the rest from the bottom.
    always_comb begin
        if (ld_op == lwl) begin
            shifted = rdata << bit_shift;
        end else begin
            shifted = rdata >> bit_shift;
        end
    end

    always_comb begin
        case (ld_op)
            lb: begin
                mem_result = {{24{shifted[7]}}, shifted[7:0]};
            end
            lbu: begin
                mem_result = {24'd0, shifted[7:0]};
            end
            lh: begin
                mem_result = {{16{shifted[15]}}, shifted[15:0]};
            end
            lhu: begin
                mem_result = {16'd0, shifted[15:0]};
            end
            default: begin
                mem_result = shifted;  // lw, lwl, lwr.
            end
        endcase
    end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [mem_pkg::data_w-1:0]     rdata,
    stage_if.consumer                      es,
    stage_if.producer                      ws,
    output logic                           fwd_valid,
    output logic [mem_pkg::reg_addr_w-1:0] fwd_dest,
    output logic [mem_pkg::data_w-1:0]     fwd_data,
    output logic [3:0]                     fwd_stall_we
);
    import mem_pkg::*;

    logic              ms_valid;
    es_to_ms_t         ms_r;
    logic [1:0]        lane_sel;
    logic [3:0]        rf_wstrb;
    logic [data_w-1:0] mem_result;
    logic [data_w-1:0] final_result;

    // Data is ready one cycle after accept, so the stage never waits on itself.
    assign es.allowin = !ms_valid || ws.allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            ms_valid <= 1'b0;
        end else if (es.allowin) begin
            ms_valid <= es.valid;
        end
        if (es.valid && es.allowin) begin
            ms_r <= es.payload;
        end
    end

    ld_decode u_ld_decode (
        .ld_op    (ms_r.ld_op),
        .addr_lo  (ms_r.alu_result[1:0]),
        .gr_we    (ms_r.gr_we),
        .lane_sel (lane_sel),
        .rf_wstrb (rf_wstrb)
    );

    ld_select u_ld_select (
        .ld_op      (ms_r.ld_op),
        .lane_sel   (lane_sel),
        .rdata      (rdata),
        .mem_result (mem_result)
    );

    assign final_result = (ms_r.ld_op != ld_none) ? mem_result : ms_r.alu_result;

    assign ws.valid                = ms_valid;
    assign ws.payload.pc           = ms_r.pc;
    assign ws.payload.final_result = final_result;
    assign ws.payload.dest         = ms_r.dest;
    assign ws.payload.rf_wstrb     = rf_wstrb;

    // Decode stage view.
    assign fwd_valid    = ms_valid && ms_r.gr_we;
    assign fwd_dest     = ms_r.dest;
    assign fwd_data     = final_result;
    assign fwd_stall_we = {4{ms_valid}} & rf_wstrb;

    // Held output also relies on the SRAM keeping rdata during the stall.
    a_hold_stable: assert property (
        @(posedge clk) disable iff (reset)
        ws.valid && !ws.allowin |=> $stable(ws.payload)
    ) else $error("memory stage payload changed under back-pressure");

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           wb_hold,
    stage_if.consumer                      ms,
    output logic                           rf_we,
    output logic [mem_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [mem_pkg::data_w-1:0]     rf_wdata,
    output logic [3:0]                     rf_wstrb,
    output logic [mem_pkg::data_w-1:0]     wb_pc
);
    import mem_pkg::*;

    logic      ws_valid;
    ms_to_ws_t ws_r;

    // A hold freezes the stage, whether it is empty or not.
    assign ms.allowin = !wb_hold;

    always_ff @(posedge clk) begin
        if (reset) begin
            ws_valid <= 1'b0;
        end else if (ms.allowin) begin
            ws_valid <= ms.valid;
        end
        if (ms.valid && ms.allowin) begin
            ws_r <= ms.payload;
        end
    end

    // Write happens on the cycle the instruction leaves.
    assign rf_we    = ws_valid && !wb_hold && (ws_r.rf_wstrb != 4'b0000);
    assign rf_waddr = ws_r.dest;
    assign rf_wdata = ws_r.final_result;
    assign rf_wstrb = ws_r.rf_wstrb;
    assign wb_pc    = ws_r.pc;

endmodule

// File: hw/mem_backend_top.sv
`timescale 1ns/1ps

module mem_backend_top #(
    parameter int ADDR_W = mem_pkg::sram_addr_w
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           es_valid,
    input  logic [mem_pkg::data_w-1:0]     es_pc,
    input  logic [mem_pkg::data_w-1:0]     es_alu_result,
    input  logic [mem_pkg::reg_addr_w-1:0] es_dest,
    input  logic                           es_gr_we,
    input  mem_pkg::ld_op_e                es_ld_op,
    output logic                           es_allowin,
    input  logic                           pre_en,
    input  logic [ADDR_W-1:0]              pre_addr,
    input  logic [mem_pkg::data_w-1:0]     pre_data,
    input  logic [3:0]                     pre_strb,
    input  logic                           wb_hold,
    output logic                           fwd_valid,
    output logic [mem_pkg::reg_addr_w-1:0] fwd_dest,
    output logic [mem_pkg::data_w-1:0]     fwd_data,
    output logic [3:0]                     fwd_stall_we,
    output logic                           rf_we,
    output logic [mem_pkg::reg_addr_w-1:0] rf_waddr,
    output logic [mem_pkg::data_w-1:0]     rf_wdata,
    output logic [3:0]                     rf_wstrb,
    output logic [mem_pkg::data_w-1:0]     wb_pc
);
    import mem_pkg::*;

    logic [data_w-1:0] rdata;

    stage_if #(.payload_t(es_to_ms_t)) es_ms ();
    stage_if #(.payload_t(ms_to_ws_t)) ms_ws ();

    // Execute side enters through plain ports.
    assign es_ms.valid              = es_valid;
    assign es_ms.payload.pc         = es_pc;
    assign es_ms.payload.alu_result = es_alu_result;
    assign es_ms.payload.dest       = es_dest;
    assign es_ms.payload.gr_we      = es_gr_we;
    assign es_ms.payload.ld_op      = es_ld_op;
    assign es_allowin               = es_ms.allowin;

    data_sram #(.ADDR_W(ADDR_W)) u_data_sram (
        .clk      (clk),
        .pre_en   (pre_en),
        .pre_addr (pre_addr),
        .pre_data (pre_data),
        .pre_strb (pre_strb),
        .es       (es_ms.monitor),
        .rdata    (rdata)
    );

    mem_stage u_mem_stage (
        .clk          (clk),
        .reset        (reset),
        .rdata        (rdata),
        .es           (es_ms.consumer),
        .ws           (ms_ws.producer),
        .fwd_valid    (fwd_valid),
        .fwd_dest     (fwd_dest),
        .fwd_data     (fwd_data),
        .fwd_stall_we (fwd_stall_we)
    );

    wb_stage u_wb_stage (
        .clk      (clk),
        .reset    (reset),
        .wb_hold  (wb_hold),
        .ms       (ms_ws.consumer),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata),
        .rf_wstrb (rf_wstrb),
        .wb_pc    (wb_pc)
    );

endmodule

// File: tests/tb_mem_backend.sv
`timescale 1ns/1ps

module tb_mem_backend;
    import mem_pkg::*;

    localparam int addr_w  = 10;
    localparam int n_words = 64;  // Loads stay inside the preloaded words.
    localparam int clk_ns  = 4;
    // Reset, preload, then six tests with their drains.
    localparam int total_cycles = 4 + (n_words + 8) + 30 + 50 + 35 + 45 + 45 + 45;

    logic              clk;
    logic              reset;
    logic              es_valid;
    logic [31:0]       es_pc;
    logic [31:0]       es_alu_result;
    logic [4:0]        es_dest;
    logic              es_gr_we;
    ld_op_e            es_ld_op;
    logic              es_allowin;
    logic              pre_en;
    logic [addr_w-1:0] pre_addr;
    logic [31:0]       pre_data;
    logic [3:0]        pre_strb;
    logic              wb_hold;
    logic              fwd_valid;
    logic [4:0]        fwd_dest;
    logic [31:0]       fwd_data;
    logic [3:0]        fwd_stall_we;
    logic              rf_we;
    logic [4:0]        rf_waddr;
    logic [31:0]       rf_wdata;
    logic [3:0]        rf_wstrb;
    logic [31:0]       wb_pc;

    logic [31:0] model_mem [n_words];
    logic [31:0] q_pc [$];
    logic [31:0] q_data [$];
    logic [4:0]  q_dest [$];
    logic [3:0]  q_strb [$];
    int          q_cyc [$];  // Accept edge of each expected write.

    int          seed;
    int          errors;
    int          cycle;
    string       test_name;
    bit          lat_check;
    bit          saw_stall;
    logic [31:0] next_pc;
    logic [31:0] r;

    mem_backend_top #(.ADDR_W(addr_w)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_ns / 2) clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // Watchdog.
    initial begin
        #(total_cycles * clk_ns + 200);
        $display("watchdog expired at %0t, the DUT stopped making progress", $time);
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    function automatic logic [31:0] load_addr(input logic [5:0] word, input logic [1:0] off);
        return {24'd0, word, off};
    endfunction

    // Little-endian MIPS load semantics on the model memory.
    function automatic void expect_result(input ld_op_e op, input logic [31:0] addr,
            input logic gr_we, output logic [31:0] data, output logic [3:0] strb);
        logic [31:0] w;
        int          k;
        w    = model_mem[addr[7:2]];
        k    = int'(addr[1:0]);
        strb = 4'hf;
        case (op)
            lb:      data = {{24{w[8*k+7]}}, w[8*k +: 8]};
            lbu:     data = {24'd0, w[8*k +: 8]};
            lh:      data = {{16{w[8*k+15]}}, w[8*k +: 16]};
            lhu:     data = {16'd0, w[8*k +: 16]};
            lw:      data = w;
            lwl:     data = w << (8 * (3 - k));  // Bytes 0..k fill the top of the register.
            lwr:     data = w >> (8 * k);        // Bytes k..3 fill the bottom.
            default: data = addr;
        endcase
        for (int i = 0; i < 4; i++) begin
            if (op == lwl) strb[i] = (i >= 3 - k);
            if (op == lwr) strb[i] = (i <= 3 - k);
        end
        if (!gr_we) strb = 4'h0;
    endfunction

    task automatic preload(input int word, input logic [31:0] data, input logic [3:0] strb);
        pre_en   = 1'b1;
        pre_addr = addr_w'(word);
        pre_data = data;
        pre_strb = strb;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) model_mem[word][8*i +: 8] = data[8*i +: 8];
        end
        @(posedge clk);
        #1;
        pre_en = 1'b0;
    endtask

    // Presents one instruction and returns after the edge that accepts it.
    task automatic issue(input ld_op_e op, input logic [31:0] addr, input logic [4:0] dest,
            input logic gr_we);
        logic [31:0] data;
        logic [3:0]  strb;
        es_valid      = 1'b1;
        es_pc         = next_pc;
        es_alu_result = addr;
        es_dest       = dest;
        es_gr_we      = gr_we;
        es_ld_op      = op;
        @(negedge clk);
        while (!es_allowin) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        expect_result(op, addr, gr_we, data, strb);
        if (strb != 4'h0) begin
            q_pc.push_back(next_pc);
            q_data.push_back(data);
            q_dest.push_back(dest);
            q_strb.push_back(strb);
            q_cyc.push_back(cycle + 1);
        end
        next_pc = next_pc + 32'd4;
        @(posedge clk);
        #1;
    endtask

    task automatic idle();
        es_valid = 1'b0;
        es_ld_op = ld_none;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle();
        while (q_data.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (q_data.size() != 0) begin
            errors++;
            $display("%s: %0d results were never written back", test_name, q_data.size());
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    // Every register write must match the oldest outstanding instruction.
    always @(negedge clk) begin
        if (!reset && rf_we) begin
            if (q_data.size() == 0) begin
                errors++;
                $display("%s: unexpected register write to r%0d", test_name, rf_waddr);
            end else begin
                check_value("rf_wdata", q_data[0], rf_wdata);
                check_value("rf_waddr", 32'(q_dest[0]), 32'(rf_waddr));
                check_value("rf_wstrb", 32'(q_strb[0]), 32'(rf_wstrb));
                check_value("wb_pc", q_pc[0], wb_pc);
                if (lat_check) check_value("write cycle", 32'(q_cyc[0] + 1), 32'(cycle));
                void'(q_pc.pop_front());
                void'(q_data.pop_front());
                void'(q_dest.pop_front());
                void'(q_strb.pop_front());
                void'(q_cyc.pop_front());
            end
        end
    end

    task automatic run_stream(input int n);
        for (int i = 0; i < n; i++) begin
            r = $random(seed);
            case (i % 4)
                0:       issue(lw, load_addr(r[5:0], 2'd0), r[12:8], 1'b1);
                1:       issue(lbu, load_addr(r[5:0], r[7:6]), r[12:8], 1'b1);
                2:       issue(lh, load_addr(r[5:0], {r[6], 1'b0}), r[12:8], 1'b1);
                default: issue(ld_none, r, r[12:8], 1'b1);
            endcase
        end
    endtask

    task automatic alu_passthrough();
        test_name = "passthrough";
        issue(ld_none, 32'h1234_5678, 5'd3, 1'b1);
        issue(ld_none, 32'hdead_beef, 5'd4, 1'b0);  // No write expected.
        issue(ld_none, 32'h0000_0001, 5'd31, 1'b1);
        drain();
    endtask

    task automatic byte_half_loads();
        test_name = "byte_half";
        for (int round = 0; round < 2; round++) begin
            r = $random(seed);
            for (int off = 0; off < 4; off++) begin
                issue(lb, load_addr(r[5:0], 2'(off)), r[12:8], 1'b1);
                issue(lbu, load_addr(r[5:0], 2'(off)), r[17:13], 1'b1);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue(lh, load_addr(r[5:0], 2'(off)), r[12:8], 1'b1);
                issue(lhu, load_addr(r[5:0], 2'(off)), r[17:13], 1'b1);
            end
        end
        drain();
    endtask

    task automatic word_merge_loads();
        test_name = "word_merge";
        r = $random(seed);
        issue(lw, load_addr(r[5:0], 2'd0), 5'd8, 1'b1);
        for (int off = 0; off < 4; off++) begin
            issue(lwl, load_addr(r[5:0], 2'(off)), 5'd9, 1'b1);
            issue(lwr, load_addr(r[5:0], 2'(off)), 5'd10, 1'b1);
        end
        drain();
    endtask

    task automatic backpressure_stream();
        test_name = "backpressure";
        lat_check = 1'b0;
        saw_stall = 1'b0;
        fork
            run_stream(12);
            begin
                repeat (3) @(posedge clk);
                #1 wb_hold = 1'b1;
                repeat (4) @(posedge clk);
                #1 wb_hold = 1'b0;
            end
        join
        drain();
        if (!saw_stall) begin
            errors++;
            $display("backpressure: es_allowin never dropped while wb_hold was high");
        end
        lat_check = 1'b1;
    endtask

    // Single loads, each checked while it sits in the memory stage.
    task automatic forwarding_view();
        ld_op_e      ops [6] = '{lw, lb, lhu, lwl, lwr, lbu};
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        gr_we;
        test_name = "forwarding";
        for (int i = 0; i < 6; i++) begin
            r     = $random(seed);
            addr  = load_addr(r[5:0], (ops[i] == lw) ? 2'd0 : {r[6], r[7] && ops[i] != lhu});
            gr_we = (i != 5);
            issue(ops[i], addr, r[12:8], gr_we);
            idle();
            expect_result(ops[i], addr, gr_we, data, strb);
            @(negedge clk);
            check_value("fwd_valid", 32'(gr_we), 32'(fwd_valid));
            check_value("fwd_stall_we", 32'(strb), 32'(fwd_stall_we));
            if (gr_we) begin
                check_value("fwd_dest", 32'(r[12:8]), 32'(fwd_dest));
                check_value("fwd_data", data, fwd_data);
            end
            @(posedge clk);
            #1;
        end
        drain();
        check_value("fwd_valid idle", 32'd0, 32'(fwd_valid));
    endtask

    initial begin
        seed          = 32'he0af_271d;
        errors        = 0;
        lat_check     = 1'b1;
        saw_stall     = 1'b0;
        next_pc       = 32'hbfc0_0000;
        test_name     = "reset";
        reset         = 1'b1;
        es_valid      = 1'b0;
        es_pc         = 32'd0;
        es_alu_result = 32'd0;
        es_dest       = 5'd0;
        es_gr_we      = 1'b0;
        es_ld_op      = ld_none;
        pre_en        = 1'b0;
        pre_addr      = '0;
        pre_data      = 32'd0;
        pre_strb      = 4'h0;
        wb_hold       = 1'b0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        @(negedge clk);
        check_value("es_allowin", 32'd1, 32'(es_allowin));
        check_value("rf_we", 32'd0, 32'(rf_we));
        check_value("fwd_valid", 32'd0, 32'(fwd_valid));
        check_value("fwd_stall_we", 32'd0, 32'(fwd_stall_we));
        @(posedge clk);
        #1;

        test_name = "preload";
        for (int w = 0; w < n_words; w++) begin
            preload(w, $random(seed), 4'hf);
        end
        for (int w = 0; w < 8; w++) begin
            preload(w, $random(seed), 4'(w + 1));  // Partial byte strobes.
        end

        alu_passthrough();
        byte_half_loads();
        word_merge_loads();
        test_name = "stream";
        run_stream(16);
        drain();
        backpressure_stream();
        forwarding_view();

        $display("tb_mem_backend finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hw/mem_pkg.sv
hw/stage_if.sv
hw/data_sram.sv
hw/ld_decode.sv
hw/ld_select.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_backend_top.sv
tests/tb_mem_backend.sv

// File: run.sh
#!/bin/sh
# Build and run the memory back-end testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mem_backend -Mdir obj_dir \
    -o sim_mem_backend -f list.f > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_mem_backend > sim.log 2>&1
cat sim.log

! grep -q "Simulation FAILED" sim.log && grep -q "Simulation PASSED" sim.log \
    && exit 0 || exit 1
